// File: design/rv32v_isa_pkg.sv
/*
 * vector instruction encodings: opcodes, funct3/funct6, width and mop codes,
 * plus the instruction word union with its arithmetic and load/store views
 */
`default_nettype none

package rv32v_isa_pkg;

  // major opcodes
  localparam logic [6:0] OP_V       = 7'b1010111;
  localparam logic [6:0] OP_LOADFP  = 7'b0000111;
  localparam logic [6:0] OP_STOREFP = 7'b0100111;

  // funct3 operand categories
  localparam logic [2:0] OPIVV = 3'b000;
  localparam logic [2:0] OPIVX = 3'b100;
  localparam logic [2:0] OPIVI = 3'b011;
  localparam logic [2:0] OPMVV = 3'b010; // vwaddu lives here
  localparam logic [2:0] OPMVX = 3'b110; // vslide1down lives here

  localparam logic [5:0] F6_VADD        = 6'b000000;
  localparam logic [5:0] F6_VSUB        = 6'b000010;
  localparam logic [5:0] F6_VAND        = 6'b001001;
  localparam logic [5:0] F6_VOR         = 6'b001010;
  localparam logic [5:0] F6_VXOR        = 6'b001011;
  localparam logic [5:0] F6_VRGATHER    = 6'b001100;
  localparam logic [5:0] F6_VSLIDE1DOWN = 6'b001111;
  localparam logic [5:0] F6_VWADDU      = 6'b110000;

  // load/store width field, vector element sizes only
  localparam logic [2:0] VW8  = 3'b000;
  localparam logic [2:0] VW16 = 3'b101;
  localparam logic [2:0] VW32 = 3'b110;

  localparam logic [1:0] MOP_UNIT     = 2'b00;
  localparam logic [1:0] MOP_UINDEXED = 2'b01;
  localparam logic [1:0] MOP_OINDEXED = 2'b11;

  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] vs1;    // also imm5 / rs1
    logic [2:0] funct3;
    logic [4:0] vd;
    logic [6:0] opcode;
  } varith_t;

  typedef struct packed {
    logic [2:0] nf;
    logic       mew;
    logic [1:0] mop;
    logic       vm;
    logic [4:0] vs2;    // lumop/sumop, or index register
    logic [4:0] rs1;
    logic [2:0] width;
    logic [4:0] vd;     // vs3 for stores
    logic [6:0] opcode;
  } vmem_t;

  typedef union packed {
    varith_t arith;
    vmem_t   mem;
  } vinstr_u;

endpackage

`default_nettype wire

// File: design/rv32v_cfg_pkg.sv
/*
 * vector unit sizes and the shared element, offset and sew types,
 * offset-source and ALU-op enums
 */
`default_nettype none

package rv32v_cfg_pkg;

  localparam int VLEN      = 128;
  localparam int NUM_VREGS = 32;
  localparam int ELEM_W    = 32;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef logic [ELEM_W-1:0] elem_t;   // zero-extended lane value
  typedef logic [31:0]       offset_t; // wide enough for rs1 and lane-data indices
  typedef logic [4:0]        vreg_t;

  typedef enum logic [2:0] {
    VS2_SRC_NORMAL,
    VS2_SRC_IDX_PLUS_1,
    VS2_SRC_VS1,
    VS2_SRC_RS1,
    VS2_SRC_UIMM
  } vs2_src_t;

  typedef enum logic {
    VD_SRC_NORMAL,
    VD_SRC_ZERO
  } vd_src_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NONE
  } aluop_t;

endpackage

`default_nettype wire

// File: design/vector_control_unit.sv
/*
 * vector control unit: combinational decode of one instruction word into
 * ALU op, load/store flags, register numbers, offset sources and widen flags
 */
`timescale 1ns/1ns
`default_nettype none

module vector_control_unit
  import rv32v_isa_pkg::*;
  import rv32v_cfg_pkg::*;
(
  input  vinstr_u    instr,
  input  logic       instr_valid,
  output logic       de_en,
  output logic       illegal,
  output aluop_t     aluop,
  output logic       is_signed,
  output logic       load,
  output logic       store,
  output logic       ls_idx,
  output logic       wen,
  output vreg_t      vs1,
  output vreg_t      vs2,
  output vreg_t      vd,
  output logic [4:0] imm5,
  output vs2_src_t   vs2_src,
  output vd_src_t    vd_src,
  output logic       vs2_widen,
  output logic       vd_widen
);

  logic [5:0] f6;
  logic [2:0] f3;
  logic       opi_form;    // one of the integer vv/vx/vi forms
  logic       mem_indexed;
  logic       mem_ok;      // load/store encoding we can walk
  logic       supported;

  assign f6 = instr.arith.funct6;
  assign f3 = instr.arith.funct3;
  assign opi_form = (f3 == OPIVV) || (f3 == OPIVX) || (f3 == OPIVI);

  // register fields sit at the same bits in both views
  assign vs1  = instr.arith.vs1;
  assign vs2  = instr.arith.vs2;
  assign vd   = instr.arith.vd;
  assign imm5 = instr.arith.vs1;

  assign mem_indexed = (instr.mem.mop == MOP_UINDEXED) || (instr.mem.mop == MOP_OINDEXED);
  assign mem_ok = (instr.mem.nf == 3'd0) && !instr.mem.mew &&
                  ((instr.mem.width == VW8) || (instr.mem.width == VW16) ||
                   (instr.mem.width == VW32)) &&
                  (mem_indexed || ((instr.mem.mop == MOP_UNIT) && (instr.mem.vs2 == 5'd0)));

  always_comb begin
    supported = 1'b0;
    aluop     = ALU_NONE;
    is_signed = 1'b0;
    load      = 1'b0;
    store     = 1'b0;
    ls_idx    = 1'b0;
    wen       = 1'b0;
    vs2_src   = VS2_SRC_NORMAL;
    vd_src    = VD_SRC_ZERO;   // parked on element 0 when nothing decodes
    vs2_widen = 1'b0;
    vd_widen  = 1'b0;
    case (instr.arith.opcode)
      OP_V: begin
        if (opi_form) begin
          supported = 1'b1;
          case (f6)
            F6_VADD: aluop = ALU_ADD;
            F6_VSUB: aluop = ALU_SUB;
            F6_VAND: aluop = ALU_AND;
            F6_VOR:  aluop = ALU_OR;
            F6_VXOR: aluop = ALU_XOR;
            F6_VRGATHER: begin
              if (f3 == OPIVV) vs2_src = VS2_SRC_VS1;
              else if (f3 == OPIVX) vs2_src = VS2_SRC_RS1;
              else vs2_src = VS2_SRC_UIMM;
            end
            default: supported = 1'b0;
          endcase
          // gather index immediate stays unsigned
          is_signed = supported && (f3 == OPIVI) && (f6 != F6_VRGATHER);
        end else if ((f3 == OPMVV) && (f6 == F6_VWADDU)) begin
          supported = 1'b1;
          aluop     = ALU_ADD;
          vs2_widen = 1'b1;
          vd_widen  = 1'b1;
        end else if ((f3 == OPMVX) && (f6 == F6_VSLIDE1DOWN)) begin
          supported = 1'b1;
          vs2_src   = VS2_SRC_IDX_PLUS_1;
        end
        wen = supported;
      end
      OP_LOADFP: begin
        supported = mem_ok;
        load      = mem_ok;
        wen       = mem_ok;
        ls_idx    = mem_ok && mem_indexed;
      end
      OP_STOREFP: begin
        supported = mem_ok;
        store     = mem_ok;   // vd field names the store data register
        ls_idx    = mem_ok && mem_indexed;
      end
      default: supported = 1'b0;
    endcase
    if (supported) vd_src = VD_SRC_NORMAL;
  end

  assign de_en   = instr_valid && supported;
  assign illegal = instr_valid && !supported;

endmodule

`default_nettype wire

// File: design/element_counter.sv
/*
 * element counter: walks the two-lane element offset from vstart toward vl,
 * flags the last pair and whether lane 1 is still inside vl
 */
`timescale 1ns/1ns
`default_nettype none

module element_counter
  import rv32v_cfg_pkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  logic    de_en,
  input  logic    stall,
  input  logic    flush,
  input  offset_t vstart,
  input  offset_t vl,
  output offset_t offset,
  output logic    last,
  output logic    lane1_active
);

  offset_t     adv;       // elements stepped past vstart
  logic [32:0] pair_end;  // offset + 2, one bit wider so it cannot wrap
  logic [32:0] lane1_idx;

  assign offset    = vstart + adv;
  assign pair_end  = {1'b0, offset} + 33'd2;
  assign lane1_idx = {1'b0, offset} + 33'd1;

  // vstart >= vl also lands here, giving a single micro-op
  assign last         = pair_end >= {1'b0, vl};
  assign lane1_active = lane1_idx < {1'b0, vl};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      adv <= '0;
    end else if (flush || !de_en) begin
      adv <= '0;                   // restart from vstart
    end else if (!stall) begin
      if (last) adv <= '0;
      else adv <= adv + 32'd2;
    end
  end

endmodule

`default_nettype wire

// File: design/vector_reg_file.sv
/*
 * vector register file: 32 x VLEN registers, whole-register write port,
 * three two-lane element read ports and the v0 mask bits
 */
`timescale 1ns/1ns
`default_nettype none

module vector_reg_file
  import rv32v_cfg_pkg::*;
(
  input  logic            CLK,
  input  logic            nRST,
  input  logic            wen,
  input  vreg_t           wsel,
  input  logic [VLEN-1:0] wdata,
  input  vreg_t           rsel1, rsel2, rsel3,
  input  offset_t [1:0]   roff1, roff2, roff3,
  input  sew_t            sew,
  input  sew_t            vs2_sew,
  output elem_t [1:0]     rdata1, rdata2, rdata3,
  output logic [1:0]      v0_bits
);

  logic [VLEN-1:0] regs [NUM_VREGS];

  // zero-extended element idx of r at width w, zero past the register end
  function automatic elem_t get_elem(input logic [VLEN-1:0] r, input offset_t idx,
                                     input sew_t w);
    elem_t e;
    e = '0;
    case (w)
      SEW8:  if (idx < VLEN/8) e[7:0] = r[idx[$clog2(VLEN/8)-1:0]*8 +: 8];
      SEW16: if (idx < VLEN/16) e[15:0] = r[idx[$clog2(VLEN/16)-1:0]*16 +: 16];
      SEW32: if (idx < VLEN/32) e = r[idx[$clog2(VLEN/32)-1:0]*32 +: 32];
      default: e = '0;
    endcase
    return e;
  endfunction

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rdata1[i]  = get_elem(regs[rsel1], roff1[i], sew);
      rdata2[i]  = get_elem(regs[rsel2], roff2[i], vs2_sew); // widened for vwaddu
      rdata3[i]  = get_elem(regs[rsel3], roff3[i], sew);
      // mask bits follow the destination element index
      v0_bits[i] = (roff3[i] < VLEN) ? regs[0][roff3[i][$clog2(VLEN)-1:0]] : 1'b0;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < NUM_VREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[wsel] <= wdata;
    end
  end

endmodule

`default_nettype wire

// File: design/rv32v_decode_stage.sv
/*
 * decode stage datapath: read/write offset selection, imm extension,
 * effective element width, mask bits and the decode-to-execute register
 */
`timescale 1ns/1ns
`default_nettype none

module rv32v_decode_stage
  import rv32v_cfg_pkg::*;
(
  input  logic          CLK, nRST, stall, flush,
  input  elem_t         xs1, xs2,
  input  sew_t          sew,
  input  offset_t       vl,
  // from the control unit
  input  logic          de_en, cu_is_signed, cu_load, cu_store, cu_ls_idx, wen,
  input  aluop_t        cu_aluop,
  input  vreg_t         vs1, vs2, vd,
  input  logic [4:0]    imm5,
  input  vs2_src_t      vs2_src,
  input  vd_src_t       vd_src,
  input  logic          vs2_widen, vd_widen, vm,
  // from the element counter
  input  offset_t       offset,
  input  logic          last, lane1_active,
  // register file
  input  elem_t [1:0]   rdata1, rdata2, rdata3,
  input  logic [1:0]    v0_bits,
  output vreg_t         rsel1, rsel2, rsel3,
  output offset_t [1:0] roff1, roff2, roff3,
  output sew_t          vs2_sew,
  // decode-to-execute bundle
  output logic          ex_valid, done, wen0, wen1, mask0, mask1,
  output elem_t         vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1, vs3_lane0, vs3_lane1,
  output offset_t       woffset0, woffset1,
  output elem_t         imm,
  output aluop_t        aluop,
  output sew_t          eew,
  output vreg_t         vd_sel,
  output logic          load, store, ls_idx, is_signed
);

  offset_t       base1, base2;  // offset+1 and offset+2
  offset_t [1:0] woff;
  elem_t         imm_sext, imm_zext, imm_d;
  sew_t          eew_d;
  logic          lane0_active;
  logic          wen0_d, wen1_d;

  // SEW8 doubles to 16, anything wider saturates at 32
  function automatic sew_t widen(input sew_t s);
    if (s == SEW8) return SEW16;
    return SEW32;
  endfunction

  assign base1 = offset + 32'd1;
  assign base2 = offset + 32'd2;

  assign rsel1 = vs1;
  assign rsel2 = vs2;
  assign rsel3 = vd;       // vs3 store data shares the vd field
  assign roff1 = {base1, offset};
  assign roff3 = woff;

  always_comb begin
    case (vs2_src)
      VS2_SRC_IDX_PLUS_1: roff2 = {base2, base1};
      VS2_SRC_VS1:        roff2 = {rdata1[1], rdata1[0]}; // gather indices from vs1 lanes
      VS2_SRC_RS1:        roff2 = {xs1, xs1};
      VS2_SRC_UIMM:       roff2 = {imm_zext, imm_zext};
      default:            roff2 = {base1, offset};
    endcase
  end

  always_comb begin
    case (vd_src)
      VD_SRC_ZERO: woff = '0;
      default:     woff = {base1, offset};
    endcase
  end

  assign imm_sext = {{(ELEM_W-5){imm5[4]}}, imm5};
  assign imm_zext = {{(ELEM_W-5){1'b0}}, imm5};
  // memory ops carry the rs2 scalar in the imm slot
  assign imm_d = (cu_load || cu_store) ? xs2 : (cu_is_signed ? imm_sext : imm_zext);

  assign vs2_sew = vs2_widen ? widen(sew) : sew;
  assign eew_d   = vd_widen ? widen(sew) : sew;

  assign lane0_active = offset < vl;
  assign wen0_d = de_en && wen && lane0_active;
  assign wen1_d = de_en && wen && lane1_active;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_valid  <= 1'b0;
      done      <= 1'b0;
      wen0      <= 1'b0;
      wen1      <= 1'b0;
      mask0     <= 1'b0;
      mask1     <= 1'b0;
      load      <= 1'b0;
      store     <= 1'b0;
      ls_idx    <= 1'b0;
      is_signed <= 1'b0;
      aluop     <= ALU_NONE;
      eew       <= SEW8;
      vd_sel    <= '0;
      imm       <= '0;
      woffset0  <= '0;
      woffset1  <= '0;
      vs1_lane0 <= '0;
      vs1_lane1 <= '0;
      vs2_lane0 <= '0;
      vs2_lane1 <= '0;
      vs3_lane0 <= '0;
      vs3_lane1 <= '0;
    end else if (flush || !stall) begin
      // flush loads an all-zero bundle
      ex_valid  <= !flush && de_en;
      done      <= !flush && de_en && last;
      wen0      <= !flush && wen0_d;
      wen1      <= !flush && wen1_d;
      mask0     <= !flush && (vm || v0_bits[0]);   // unmasked ops see all ones
      mask1     <= !flush && (vm || v0_bits[1]);
      load      <= !flush && cu_load;
      store     <= !flush && cu_store;
      ls_idx    <= !flush && cu_ls_idx;
      is_signed <= !flush && cu_is_signed;
      aluop     <= flush ? ALU_NONE : cu_aluop;
      eew       <= flush ? SEW8 : eew_d;
      vd_sel    <= flush ? '0 : vd;
      imm       <= flush ? '0 : imm_d;
      woffset0  <= flush ? '0 : woff[0];
      woffset1  <= flush ? '0 : woff[1];
      vs1_lane0 <= flush ? '0 : rdata1[0];
      vs1_lane1 <= flush ? '0 : rdata1[1];
      vs2_lane0 <= flush ? '0 : rdata2[0];
      vs2_lane1 <= flush ? '0 : rdata2[1];
      vs3_lane0 <= flush ? '0 : rdata3[0];
      vs3_lane1 <= flush ? '0 : rdata3[1];
    end else begin
      done <= 1'b0;   // stalled, bundle held
    end
  end

endmodule

`default_nettype wire

// File: design/rv32v_decode_top.sv
/*
 * decode top: control unit, element counter, register file and decode stage
 */
`timescale 1ns/1ns
`default_nettype none

module rv32v_decode_top
  import rv32v_isa_pkg::*;
  import rv32v_cfg_pkg::*;
(
  input  logic            CLK, nRST,
  input  vinstr_u         instr,
  input  logic            instr_valid,
  input  elem_t           xs1, xs2,
  input  offset_t         vl, vstart,
  input  sew_t            sew,
  input  logic            stall, flush,
  input  logic            rf_wen,
  input  vreg_t           rf_wsel,
  input  logic [VLEN-1:0] rf_wdata,
  output logic            done, ex_valid,
  output elem_t           vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1, vs3_lane0, vs3_lane1,
  output offset_t         woffset0, woffset1,
  output logic            wen0, wen1, mask0, mask1,
  output elem_t           imm,
  output aluop_t          aluop,
  output sew_t            eew,
  output vreg_t           vd_sel,
  output logic            load, store, ls_idx, is_signed
);

  // control unit outputs
  logic       de_en, wen, vs2_widen, vd_widen;
  logic       cu_is_signed, cu_load, cu_store, cu_ls_idx;
  aluop_t     cu_aluop;
  vreg_t      vs1, vs2, vd;
  logic [4:0] imm5;
  vs2_src_t   vs2_src;
  vd_src_t    vd_src;

  // element counter
  offset_t offset;
  logic    last, lane1_active;

  // register file ports
  vreg_t         rsel1, rsel2, rsel3;
  offset_t [1:0] roff1, roff2, roff3;
  elem_t [1:0]   rdata1, rdata2, rdata3;
  logic [1:0]    v0_bits;
  sew_t          vs2_sew;

  vector_control_unit vcu (.*, .illegal(), .aluop(cu_aluop), .is_signed(cu_is_signed),
                           .load(cu_load), .store(cu_store), .ls_idx(cu_ls_idx));

  element_counter ele_cnt (.*);

  vector_reg_file vrf (.*, .wen(rf_wen), .wsel(rf_wsel), .wdata(rf_wdata));

  rv32v_decode_stage dec (.*, .vm(instr.arith.vm));

endmodule

`default_nettype wire

// File: sim/rv32v_decode_assertions.sv
/*
 * concurrent checks on the decode top's bundle protocol, bound into the top
 */
`timescale 1ns/1ns
`default_nettype none

module rv32v_decode_assertions
  import rv32v_cfg_pkg::*;
(
  input logic    CLK, nRST, stall, flush,
  input logic    ex_valid, done, wen0, wen1,
  input offset_t woffset0, woffset1,
  input elem_t   vs1_lane0, vs2_lane0, vs2_lane1, vs3_lane0
);

  int unsigned fail_count = 0;   // read by the testbench at the end of the run

  a_wen_order: assert property (@(posedge CLK) disable iff (!nRST) wen1 |-> wen0)
    else begin
      fail_count = fail_count + 1;
      $error("wen1 high while wen0 is low");
    end

  a_done_valid: assert property (@(posedge CLK) disable iff (!nRST) done |-> ex_valid)
    else begin
      fail_count = fail_count + 1;
      $error("done without ex_valid");
    end

  // a stalled cycle keeps the bundle and drops done
  a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (stall && !flush) |=> ($stable(ex_valid) && $stable(wen0) && $stable(woffset0) &&
      $stable(woffset1) && $stable(vs1_lane0) && $stable(vs2_lane0) &&
      $stable(vs2_lane1) && $stable(vs3_lane0) && !done))
    else begin
      fail_count = fail_count + 1;
      $error("bundle changed under stall");
    end

  a_flush_clear: assert property (@(posedge CLK) disable iff (!nRST) flush |=> !ex_valid)
    else begin
      fail_count = fail_count + 1;
      $error("ex_valid high after flush");
    end

endmodule

bind rv32v_decode_top rv32v_decode_assertions u_assert (.*);

`default_nettype wire

// File: sim/tb_rv32v_decode.sv
/*
 * random-stimulus testbench for the vector decode top with a register file
 * mirror, a reference model of each micro-op bundle and typed compare tasks
 */
`timescale 1ns/1ns
`default_nettype none

module tb_rv32v_decode
  import rv32v_isa_pkg::*;
  import rv32v_cfg_pkg::*;
();

  localparam int UOP_TIMEOUT = 200;  // cycles allowed per instruction
  localparam int KIND_ARITH  = 0;
  localparam int KIND_GATHER = 1;
  localparam int KIND_SLIDE  = 2;
  localparam int KIND_WIDEN  = 3;
  localparam int KIND_MEM    = 4;

  logic            CLK, nRST;
  vinstr_u         instr;
  logic            instr_valid, stall, flush, rf_wen;
  elem_t           xs1, xs2;
  offset_t         vl, vstart;
  sew_t            sew;
  vreg_t           rf_wsel;
  logic [VLEN-1:0] rf_wdata;
  logic            done, ex_valid, wen0, wen1, mask0, mask1, load, store, ls_idx, is_signed;
  elem_t           vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1, vs3_lane0, vs3_lane1, imm;
  offset_t         woffset0, woffset1;
  aluop_t          aluop;
  sew_t            eew;
  vreg_t           vd_sel;

  integer          seed = 32'h68b2;
  logic [VLEN-1:0] model_regs [NUM_VREGS];

  // expected decode of the instruction in flight
  aluop_t   m_aluop;
  vs2_src_t m_vs2_src;
  logic     m_widen, m_signed, m_load, m_store, m_ls_idx, m_wen;

  // bundle seen at the previous falling edge
  elem_t   held_lane [7];
  offset_t held_woff [2];
  logic    held_valid, held_wen0, held_wen1, held_mask0, held_mask1;
  aluop_t  held_aluop;

  rv32v_decode_top u_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_lane(input string name, input elem_t exp, input elem_t act);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_offset(input string name, input offset_t exp, input offset_t act);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_vreg(input string name, input vreg_t exp, input vreg_t act);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_aluop(input string name, input aluop_t exp, input aluop_t act);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s expected %s got %s", $time, name, exp.name(), act.name());
      stop_with_failure();
    end
  endtask

  task automatic check_sew(input string name, input sew_t exp, input sew_t act);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s expected %s got %s", $time, name, exp.name(), act.name());
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s expected %b got %b", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic sew_t wide_sew(input sew_t s);
    return (s == SEW8) ? SEW16 : SEW32;
  endfunction

  // element idx of register r at width s and zero past the register end
  function automatic elem_t model_elem(input vreg_t r, input offset_t idx, input sew_t s);
    int unsigned     w;
    logic [VLEN-1:0] sh;
    w = 32'd8 << s;
    if (idx >= VLEN / w) return '0;
    sh = model_regs[r] >> (idx * w);
    case (s)
      SEW8:    return {24'd0, sh[7:0]};
      SEW16:   return {16'd0, sh[15:0]};
      default: return sh[31:0];
    endcase
  endfunction

  function automatic logic model_mask(input logic vm, input offset_t idx);
    if (vm) return 1'b1;
    return (idx < VLEN) ? model_regs[0][idx[$clog2(VLEN)-1:0]] : 1'b0;
  endfunction

  task automatic write_vreg(input vreg_t r, input logic [VLEN-1:0] data);
    @(negedge CLK);
    rf_wen        = 1'b1;
    rf_wsel       = r;
    rf_wdata      = data;
    model_regs[r] = data;
    @(negedge CLK);
    rf_wen = 1'b0;
  endtask

  task automatic random_config();
    sew    = sew_t'(rnd(3));
    vl     = rnd(20);
    vstart = (rnd(5) == 0) ? vl + rnd(2) : rnd(vl + 1);  // sometimes past vl
    xs1    = rnd(2) ? elem_t'(rnd(20)) : elem_t'($random(seed));
    xs2    = $random(seed);
  endtask

  task automatic make_instr(input int kind, output vinstr_u ins);
    logic [2:0] f3;
    logic [5:0] f6_tab [5];
    aluop_t     op_tab [5];
    int         j;
    f6_tab = '{F6_VADD, F6_VSUB, F6_VAND, F6_VOR, F6_VXOR};
    op_tab = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
    case (rnd(3))
      0:       f3 = OPIVV;
      1:       f3 = OPIVX;
      default: f3 = OPIVI;
    endcase
    ins = '0;
    ins.arith.vm     = rnd(2);
    ins.arith.vs2    = rnd(32);
    ins.arith.vs1    = rnd(32);
    ins.arith.vd     = rnd(32);
    ins.arith.funct3 = f3;
    ins.arith.opcode = OP_V;
    m_aluop   = ALU_NONE;
    m_vs2_src = VS2_SRC_NORMAL;
    m_widen   = 1'b0;
    m_signed  = 1'b0;
    m_load    = 1'b0;
    m_store   = 1'b0;
    m_ls_idx  = 1'b0;
    m_wen     = 1'b1;
    case (kind)
      KIND_ARITH: begin
        j = rnd(5);
        ins.arith.funct6 = f6_tab[j];
        m_aluop  = op_tab[j];
        m_signed = (f3 == OPIVI);
      end
      KIND_GATHER: begin
        ins.arith.funct6 = F6_VRGATHER;
        if (f3 == OPIVV) begin
          ins.arith.vs1 = 5'd8 + 5'(rnd(8));  // small index values live in v8..v15
          m_vs2_src = VS2_SRC_VS1;
        end else begin
          m_vs2_src = (f3 == OPIVX) ? VS2_SRC_RS1 : VS2_SRC_UIMM;
        end
      end
      KIND_SLIDE: begin
        ins.arith.funct6 = F6_VSLIDE1DOWN;
        ins.arith.funct3 = OPMVX;
        m_vs2_src        = VS2_SRC_IDX_PLUS_1;
      end
      KIND_WIDEN: begin
        ins.arith.funct6 = F6_VWADDU;
        ins.arith.funct3 = OPMVV;
        m_aluop          = ALU_ADD;
        m_widen          = 1'b1;
      end
      default: begin
        case (rnd(3))
          0:       ins.mem.mop = MOP_UNIT;
          1:       ins.mem.mop = MOP_UINDEXED;
          default: ins.mem.mop = MOP_OINDEXED;
        endcase
        case (rnd(3))
          0:       ins.mem.width = VW8;
          1:       ins.mem.width = VW16;
          default: ins.mem.width = VW32;
        endcase
        if (ins.mem.mop == MOP_UNIT) ins.mem.vs2 = 5'd0;  // lumop unit-stride
        ins.mem.opcode = rnd(2) ? OP_LOADFP : OP_STOREFP;
        m_load   = (ins.mem.opcode == OP_LOADFP);
        m_store  = !m_load;
        m_ls_idx = (ins.mem.mop != MOP_UNIT);
        m_wen    = m_load;
      end
    endcase
  endtask

  task automatic snapshot();
    held_lane  = '{vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1, vs3_lane0, vs3_lane1, imm};
    held_woff  = '{woffset0, woffset1};
    held_valid = ex_valid;
    held_wen0  = wen0;
    held_wen1  = wen1;
    held_mask0 = mask0;
    held_mask1 = mask1;
    held_aluop = aluop;
  endtask

  task automatic check_held();
    check_lane("vs1_lane0", held_lane[0], vs1_lane0);
    check_lane("vs1_lane1", held_lane[1], vs1_lane1);
    check_lane("vs2_lane0", held_lane[2], vs2_lane0);
    check_lane("vs2_lane1", held_lane[3], vs2_lane1);
    check_lane("vs3_lane0", held_lane[4], vs3_lane0);
    check_lane("vs3_lane1", held_lane[5], vs3_lane1);
    check_lane("imm", held_lane[6], imm);
    check_offset("woffset0", held_woff[0], woffset0);
    check_offset("woffset1", held_woff[1], woffset1);
    check_bit("ex_valid", held_valid, ex_valid);
    check_bit("wen0", held_wen0, wen0);
    check_bit("wen1", held_wen1, wen1);
    check_bit("mask0", held_mask0, mask0);
    check_bit("mask1", held_mask1, mask1);
    check_aluop("aluop", held_aluop, aluop);
    check_bit("done", 1'b0, done);  // no done while stalled
  endtask

  task automatic check_uop(input vinstr_u ins, input int k);
    offset_t off, idx0, idx1;
    sew_t    rsew;
    elem_t   exp_imm;
    off  = vstart + offset_t'(2 * k);
    rsew = m_widen ? wide_sew(sew) : sew;
    case (m_vs2_src)
      VS2_SRC_IDX_PLUS_1: begin
        idx0 = off + 1;
        idx1 = off + 2;
      end
      VS2_SRC_VS1: begin
        idx0 = model_elem(ins.arith.vs1, off, sew);
        idx1 = model_elem(ins.arith.vs1, off + 1, sew);
      end
      VS2_SRC_RS1: begin
        idx0 = xs1;
        idx1 = xs1;
      end
      VS2_SRC_UIMM: begin
        idx0 = {27'd0, ins.arith.vs1};
        idx1 = {27'd0, ins.arith.vs1};
      end
      default: begin
        idx0 = off;
        idx1 = off + 1;
      end
    endcase
    if (m_load || m_store) exp_imm = xs2;
    else if (m_signed) exp_imm = {{27{ins.arith.vs1[4]}}, ins.arith.vs1};
    else exp_imm = {27'd0, ins.arith.vs1};
    check_bit("ex_valid", 1'b1, ex_valid);
    check_bit("done", (off + 2) >= vl, done);
    check_bit("wen0", m_wen && (off < vl), wen0);
    check_bit("wen1", m_wen && ((off + 1) < vl), wen1);
    check_bit("mask0", model_mask(ins.arith.vm, off), mask0);
    check_bit("mask1", model_mask(ins.arith.vm, off + 1), mask1);
    check_bit("load", m_load, load);
    check_bit("store", m_store, store);
    check_bit("ls_idx", m_ls_idx, ls_idx);
    check_bit("is_signed", m_signed, is_signed);
    check_lane("vs1_lane0", model_elem(ins.arith.vs1, off, sew), vs1_lane0);
    check_lane("vs1_lane1", model_elem(ins.arith.vs1, off + 1, sew), vs1_lane1);
    check_lane("vs2_lane0", model_elem(ins.arith.vs2, idx0, rsew), vs2_lane0);
    check_lane("vs2_lane1", model_elem(ins.arith.vs2, idx1, rsew), vs2_lane1);
    check_lane("vs3_lane0", model_elem(ins.arith.vd, off, sew), vs3_lane0);
    check_lane("vs3_lane1", model_elem(ins.arith.vd, off + 1, sew), vs3_lane1);
    check_lane("imm", exp_imm, imm);
    check_offset("woffset0", off, woffset0);
    check_offset("woffset1", off + 1, woffset1);
    check_aluop("aluop", m_aluop, aluop);
    check_sew("eew", m_widen ? wide_sew(sew) : sew, eew);
    check_vreg("vd_sel", ins.arith.vd, vd_sel);
  endtask

  // hold one instruction until done and check every bundle on the way
  task automatic run_instr(input vinstr_u ins, input logic do_stall, input logic do_flush);
    int   k, n_uop, cycles;
    logic was_stall, was_flush, flushed, finished;
    @(negedge CLK);
    snapshot();
    random_config();
    instr       = ins;
    instr_valid = 1'b1;
    stall       = do_stall && (rnd(3) == 0);
    flush       = 1'b0;
    n_uop    = (vstart >= vl) ? 1 : int'((vl - vstart + 32'd1) / 32'd2);
    k        = 0;
    cycles   = 0;
    flushed  = 1'b0;
    finished = 1'b0;
    while (!finished) begin
      was_stall = stall;
      was_flush = flush;
      @(negedge CLK);
      cycles++;
      if (cycles > UOP_TIMEOUT) begin
        $display("ERROR at %0t ns: done did not arrive within %0d cycles", $time, UOP_TIMEOUT);
        stop_with_failure();
      end
      if (was_flush) begin
        check_bit("ex_valid", 1'b0, ex_valid);
        check_bit("done", 1'b0, done);
        check_bit("wen0", 1'b0, wen0);
        check_bit("wen1", 1'b0, wen1);
        check_offset("woffset0", '0, woffset0);
        check_lane("vs2_lane0", '0, vs2_lane0);
        k = 0;   // walk restarts from vstart
      end else if (was_stall) begin
        check_held();
      end else begin
        check_uop(ins, k);
        k++;
        finished = (k == n_uop);
      end
      snapshot();
      flush       = do_flush && !flushed && !finished && (k >= 1);
      flushed     = flushed || flush;
      stall       = !finished && !flush && do_stall && (rnd(3) == 0);
      instr_valid = !finished;
    end
  endtask

  initial begin
    logic [VLEN-1:0] data;
    elem_t           word;
    vinstr_u         ins;
    nRST        = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    xs1         = '0;
    xs2         = '0;
    vl          = '0;
    vstart      = '0;
    sew         = SEW8;
    stall       = 1'b0;
    flush       = 1'b0;
    rf_wen      = 1'b0;
    rf_wsel     = '0;
    rf_wdata    = '0;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    for (int r = 0; r < NUM_VREGS; r++) begin
      for (int w = 0; w < VLEN / 32; w++) begin
        word = $random(seed);
        if (r >= 8 && r < 16) word = word & 32'h13;  // small gather indices, partly out of range
        data[w*32 +: 32] = word;
      end
      write_vreg(vreg_t'(r), data);
    end
    repeat (30) begin
      make_instr(KIND_ARITH, ins);
      run_instr(ins, 1'b0, 1'b0);
    end
    repeat (20) begin
      make_instr(KIND_GATHER, ins);
      run_instr(ins, 1'b0, 1'b0);
    end
    repeat (8) begin
      make_instr(KIND_SLIDE, ins);
      run_instr(ins, 1'b0, 1'b0);
    end
    repeat (8) begin
      make_instr(KIND_WIDEN, ins);
      run_instr(ins, 1'b0, 1'b0);
    end
    repeat (20) begin
      make_instr(KIND_MEM, ins);
      run_instr(ins, 1'b0, 1'b0);
    end
    // back-pressure and mid-instruction flush over every kind
    repeat (40) begin
      make_instr(rnd(5), ins);
      run_instr(ins, 1'b1, rnd(2));
    end
    @(negedge CLK);
    if (u_dut.u_assert.fail_count != 0) begin
      $display("ERROR: %0d concurrent assertion failures", u_dut.u_assert.fail_count);
      stop_with_failure();
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sources.f
design/rv32v_isa_pkg.sv
design/rv32v_cfg_pkg.sv
design/vector_control_unit.sv
design/element_counter.sv
design/vector_reg_file.sv
design/rv32v_decode_stage.sv
design/rv32v_decode_top.sv
sim/rv32v_decode_assertions.sv
sim/tb_rv32v_decode.sv

// File: Makefile
SIM       = verilator
TOP       = tb_rv32v_decode
FILELIST  = sources.f
SIM_FLAGS = --binary --timing --assert -Wno-fatal --top-module $(TOP)
RUN_ARGS  = +verilator+error+limit+100
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
